//--- src/exec_core_pkg.sv
// -------------------------------------------------------------------------
// execution slice package
// shared opcode and ALU enums, the decode and execute records, and the
// host-visible Wishbone address map
// -------------------------------------------------------------------------

package exec_core_pkg;

    // -------------------------------------------------------------------------
    // encodings

    // major opcodes kept by the slice, low two bits 2'b11 included
    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011
    } opcode_e;

    // ALU operations, pass_b carries the LUI immediate through
    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_SLL    = 4'd2,
        ALU_SLT    = 4'd3,
        ALU_SLTU   = 4'd4,
        ALU_XOR    = 4'd5,
        ALU_SRL    = 4'd6,
        ALU_SRA    = 4'd7,
        ALU_OR     = 4'd8,
        ALU_AND    = 4'd9,
        ALU_PASS_B = 4'd10
    } alu_op_e;

    // -------------------------------------------------------------------------
    // stage records

    // decode stage output
    typedef struct packed {
        logic        valid;
        logic        illegal;
        alu_op_e     alu_op;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  rd;
        logic        use_imm;
        logic        reg_write;
        logic [31:0] imm;
    } decoded_op_t;

    // execute stage output, write already masked for x0 and illegal ops
    typedef struct packed {
        logic        valid;
        logic        illegal;
        logic        write;
        logic [4:0]  rd;
        logic [31:0] value;
    } exec_result_t;

    // host address map, byte addresses
    localparam logic [11:0] WB_ADDR_INSTR    = 12'h000;
    localparam logic [11:0] WB_ADDR_STATUS   = 12'h004;
    localparam logic [11:0] WB_ADDR_REG_BASE = 12'h100;

endpackage

//--- src/instr_decoder.sv
// -------------------------------------------------------------------------
// instruction decoder
// splits a 32-bit RV32I word into fields, picks the ALU operation and
// registers a decode record with illegal encodings flagged
// -------------------------------------------------------------------------

module instr_decoder #(
    parameter int unsigned REG_COUNT = 32
) (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       instr_valid,
    input  logic [31:0]                instr,
    output exec_core_pkg::decoded_op_t dec
);

    // -------------------------------------------------------------------------
    // field slicing

    exec_core_pkg::opcode_e     opcode;
    logic [2:0]                 funct3;
    logic [6:0]                 funct7;
    logic [4:0]                 rs1;
    logic [4:0]                 rs2;
    logic [4:0]                 rd;
    logic                       funct7_zero;
    logic                       funct7_alt;
    exec_core_pkg::alu_op_e     base_op;
    exec_core_pkg::decoded_op_t dec_next;

    assign opcode = exec_core_pkg::opcode_e'(instr[6:0]);
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];
    assign rd     = instr[11:7];

    // funct7 is either all zero or only bit 5 set for SUB / SRA
    assign funct7_zero = (funct7 == 7'b0000000);
    assign funct7_alt  = (funct7 == 7'b0100000);

    // funct3 gives the op for both ALU groups
    always_comb
    begin
        case (funct3)
            3'b000:  base_op = exec_core_pkg::ALU_ADD;
            3'b001:  base_op = exec_core_pkg::ALU_SLL;
            3'b010:  base_op = exec_core_pkg::ALU_SLT;
            3'b011:  base_op = exec_core_pkg::ALU_SLTU;
            3'b100:  base_op = exec_core_pkg::ALU_XOR;
            3'b101:  base_op = exec_core_pkg::ALU_SRL;
            3'b110:  base_op = exec_core_pkg::ALU_OR;
            default: base_op = exec_core_pkg::ALU_AND;
        endcase
    end

    // -------------------------------------------------------------------------
    // main case

    always_comb
    begin
        // defaults with the I-type immediate sign extended
        dec_next           = '0;
        dec_next.valid     = instr_valid;
        dec_next.alu_op    = base_op;
        dec_next.rs1       = rs1;
        dec_next.rs2       = rs2;
        dec_next.rd        = rd;
        dec_next.reg_write = 1'b1;
        dec_next.imm       = {{20{instr[31]}}, instr[31:20]};

        case (opcode)
            exec_core_pkg::OPC_LUI:
            begin
                // U-type value already in place
                dec_next.alu_op  = exec_core_pkg::ALU_PASS_B;
                dec_next.use_imm = 1'b1;
                dec_next.rs1     = 5'd0;
                dec_next.rs2     = 5'd0;
                dec_next.imm     = {instr[31:12], 12'b0};
                dec_next.illegal = (rd >= REG_COUNT);
            end

            exec_core_pkg::OPC_OP_IMM:
            begin
                dec_next.use_imm = 1'b1;
                dec_next.rs2     = 5'd0;
                // only the shift immediates constrain funct7
                if (funct3 == 3'b101 && funct7_alt)
                    dec_next.alu_op = exec_core_pkg::ALU_SRA;
                dec_next.illegal = (rd >= REG_COUNT) || (rs1 >= REG_COUNT)
                    || (funct3 == 3'b001 && !funct7_zero)
                    || (funct3 == 3'b101 && !funct7_zero && !funct7_alt);
            end

            exec_core_pkg::OPC_OP:
            begin
                // bit 5 of funct7 selects SUB and SRA only
                if (funct7_alt && funct3 == 3'b000)
                    dec_next.alu_op = exec_core_pkg::ALU_SUB;
                if (funct7_alt && funct3 == 3'b101)
                    dec_next.alu_op = exec_core_pkg::ALU_SRA;
                dec_next.illegal = (rd >= REG_COUNT) || (rs1 >= REG_COUNT)
                    || (rs2 >= REG_COUNT)
                    || !(funct7_zero || (funct7_alt && (funct3 == 3'b000 || funct3 == 3'b101)));
            end

            default:
            begin
                // anything outside the kept groups
                dec_next.illegal = 1'b1;
            end
        endcase

        if (dec_next.illegal)
            dec_next.reg_write = 1'b0;
    end

    // decode stage register
    always_ff @(posedge clk)
    begin
        if (reset)
            dec.valid <= 1'b0;
        else
            dec <= dec_next;
    end

endmodule

//--- src/int_alu.sv
// -------------------------------------------------------------------------
// integer ALU, execute stage
// reads operands with a bypass from its own result and registers the
// ALU result for writeback
// -------------------------------------------------------------------------

module int_alu #(
    parameter int unsigned REG_COUNT = 32
) (
    input  logic                        clk,
    input  logic                        reset,
    input  exec_core_pkg::decoded_op_t  dec,
    input  logic [31:0]                 rs1_data,
    input  logic [31:0]                 rs2_data,
    output logic [4:0]                  rs1_idx,
    output logic [4:0]                  rs2_idx,
    output exec_core_pkg::exec_result_t res
);

    logic [31:0]                 op_a;
    logic [31:0]                 rs2_val;
    logic [31:0]                 op_b;
    logic [4:0]                  shamt;
    logic [31:0]                 alu_out;
    exec_core_pkg::exec_result_t res_next;

    assign rs1_idx = dec.rs1;
    assign rs2_idx = dec.rs2;

    // -------------------------------------------------------------------------
    // operand select

    // res.write is already low for x0, so a match means a live value
    assign op_a = (res.valid && res.write && res.rd == dec.rs1) ? res.value : rs1_data;
    assign rs2_val = (res.valid && res.write && res.rd == dec.rs2) ? res.value : rs2_data;
    assign op_b = dec.use_imm ? dec.imm : rs2_val;

    // shift amount is the low 5 bits of the second operand
    assign shamt = op_b[4:0];

    always_comb
    begin
        case (dec.alu_op)
            exec_core_pkg::ALU_ADD:  alu_out = op_a + op_b;
            exec_core_pkg::ALU_SUB:  alu_out = op_a - op_b;
            exec_core_pkg::ALU_SLL:  alu_out = op_a << shamt;
            exec_core_pkg::ALU_SLT:  alu_out = {31'b0, $signed(op_a) < $signed(op_b)};
            exec_core_pkg::ALU_SLTU: alu_out = {31'b0, op_a < op_b};
            exec_core_pkg::ALU_XOR:  alu_out = op_a ^ op_b;
            exec_core_pkg::ALU_SRL:  alu_out = op_a >> shamt;
            exec_core_pkg::ALU_SRA:  alu_out = $unsigned($signed(op_a) >>> shamt);
            exec_core_pkg::ALU_OR:   alu_out = op_a | op_b;
            exec_core_pkg::ALU_AND:  alu_out = op_a & op_b;
            default:                 alu_out = op_b;
        endcase
    end

    // -------------------------------------------------------------------------
    // result register

    always_comb
    begin
        res_next.valid   = dec.valid;
        res_next.illegal = dec.illegal;
        res_next.write   = dec.reg_write && !dec.illegal && (dec.rd != 5'd0);
        res_next.rd      = dec.rd;
        res_next.value   = alu_out;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            res.valid <= 1'b0;
        else
            res <= res_next;
    end

endmodule

//--- src/reg_writeback.sv
// -------------------------------------------------------------------------
// result stage
// architectural register file with two operand read ports, one host read
// port and the illegal-instruction counter
// -------------------------------------------------------------------------

module reg_writeback #(
    parameter int unsigned REG_COUNT = 32
) (
    input  logic                        clk,
    input  logic                        reset,
    input  exec_core_pkg::exec_result_t res,
    input  logic [4:0]                  rs1_idx,
    input  logic [4:0]                  rs2_idx,
    input  logic [4:0]                  rd_idx_host,
    output logic [31:0]                 rs1_data,
    output logic [31:0]                 rs2_data,
    output logic [31:0]                 rd_data_host,
    output logic [31:0]                 illegal_count
);

    logic [31:0] regs [REG_COUNT];

    // -------------------------------------------------------------------------
    // write port

    // architectural state starts at zero, x0 never written
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int i = 0; i < REG_COUNT; i++)
                regs[i] <= 32'd0;
        end
        else if (res.valid && res.write && res.rd != 5'd0 && res.rd < REG_COUNT)
        begin
            regs[res.rd] <= res.value;
        end
    end

    // one count per retired illegal op
    always_ff @(posedge clk)
    begin
        if (reset)
            illegal_count <= 32'd0;
        else if (res.valid && res.illegal)
            illegal_count <= illegal_count + 32'd1;
    end

    // -------------------------------------------------------------------------
    // read ports
    // x0 and indices past REG_COUNT read zero

    assign rs1_data = (rs1_idx == 5'd0 || rs1_idx >= REG_COUNT) ? 32'd0 : regs[rs1_idx];
    assign rs2_data = (rs2_idx == 5'd0 || rs2_idx >= REG_COUNT) ? 32'd0 : regs[rs2_idx];
    assign rd_data_host = (rd_idx_host == 5'd0 || rd_idx_host >= REG_COUNT) ? 32'd0
                                                                           : regs[rd_idx_host];

endmodule

//--- src/wb_instr_port.sv
// -------------------------------------------------------------------------
// Wishbone classic slave port
// instruction pushes feed the decoder, reads wait for the pipeline to
// drain and return a register or the illegal count
// -------------------------------------------------------------------------

module wb_instr_port #(
    parameter int unsigned REG_COUNT = 32
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        cyc,
    input  logic        stb,
    input  logic        we,
    input  logic [11:0] adr,
    input  logic [31:0] dat_i,
    // byte lanes accepted but unused, full words only
    input  logic [3:0]  sel,
    input  logic [2:0]  pipe_busy,
    input  logic [31:0] rd_data_host,
    input  logic [31:0] illegal_count,
    output logic [31:0] dat_o,
    output logic        ack,
    output logic        instr_valid,
    output logic [31:0] instr,
    output logic [4:0]  rd_idx_host
);

    typedef enum logic [1:0] {
        PORT_IDLE,
        PORT_WAIT_DRAIN,
        PORT_ACK
    } port_state_e;

    port_state_e state;
    logic        access;
    logic [11:0] reg_offset;
    logic        reg_hit;
    logic [31:0] read_mux;

    assign access = cyc && stb && (state == PORT_IDLE);

    // push goes straight to decode in the accept cycle
    assign instr_valid = access && we && (adr == exec_core_pkg::WB_ADDR_INSTR);
    assign instr       = dat_i;

    // -------------------------------------------------------------------------
    // read address decode

    assign reg_offset  = adr - exec_core_pkg::WB_ADDR_REG_BASE;
    assign reg_hit     = (adr >= exec_core_pkg::WB_ADDR_REG_BASE) && (adr[1:0] == 2'b00)
                         && (reg_offset[11:2] < REG_COUNT);
    assign rd_idx_host = reg_offset[6:2];

    // unmapped reads return zero
    assign read_mux = reg_hit ? rd_data_host
                    : (adr == exec_core_pkg::WB_ADDR_STATUS) ? illegal_count : 32'd0;

    // ack is a single cycle, state driven
    assign ack = (state == PORT_ACK);

    always_ff @(posedge clk)
    begin
        if (reset)
            state <= PORT_IDLE;
        else
        begin
            case (state)
                PORT_IDLE:
                    // writes ack next cycle, reads wait for drain
                    if (access)
                        state <= we ? PORT_ACK : PORT_WAIT_DRAIN;
                PORT_WAIT_DRAIN:
                    if (pipe_busy == 3'b000)
                        state <= PORT_ACK;
                default:
                    state <= PORT_IDLE;
            endcase
        end
    end

    // read data captured once every earlier push has retired
    always_ff @(posedge clk)
    begin
        if (state == PORT_WAIT_DRAIN && pipe_busy == 3'b000)
            dat_o <= read_mux;
    end

endmodule

//--- src/decode_exec_top.sv
// -------------------------------------------------------------------------
// decode / execute slice top
// Wishbone port feeding the decode, execute and result stages
// -------------------------------------------------------------------------

module decode_exec_top #(
    parameter int unsigned REG_COUNT = 32
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        cyc,
    input  logic        stb,
    input  logic        we,
    input  logic [11:0] adr,
    input  logic [31:0] dat_i,
    input  logic [3:0]  sel,
    output logic [31:0] dat_o,
    output logic        ack
);

    logic                        instr_valid;
    logic [31:0]                 instr;
    exec_core_pkg::decoded_op_t  dec;
    exec_core_pkg::exec_result_t res;
    logic [4:0]                  rs1_idx;
    logic [4:0]                  rs2_idx;
    logic [31:0]                 rs1_data;
    logic [31:0]                 rs2_data;
    logic [4:0]                  rd_idx_host;
    logic [31:0]                 rd_data_host;
    logic [31:0]                 illegal_count;
    logic [2:0]                  pipe_busy;

    // push, decode and execute valids
    assign pipe_busy = {res.valid, dec.valid, instr_valid};

    wb_instr_port #(.REG_COUNT(REG_COUNT)) port_i (
        .clk, .reset, .cyc, .stb, .we, .adr, .dat_i, .sel, .pipe_busy,
        .rd_data_host, .illegal_count, .dat_o, .ack, .instr_valid, .instr, .rd_idx_host
    );

    instr_decoder #(.REG_COUNT(REG_COUNT)) decoder_i (
        .clk, .reset, .instr_valid, .instr, .dec
    );

    int_alu #(.REG_COUNT(REG_COUNT)) alu_i (
        .clk, .reset, .dec, .rs1_data, .rs2_data, .rs1_idx, .rs2_idx, .res
    );

    reg_writeback #(.REG_COUNT(REG_COUNT)) writeback_i (
        .clk, .reset, .res, .rs1_idx, .rs2_idx, .rd_idx_host,
        .rs1_data, .rs2_data, .rd_data_host, .illegal_count
    );

endmodule

//--- test/tb_clock_gen.sv
// --------------------------------------------------------------------------
// testbench clock and reset generator
// free-running clock, synchronous active-high reset held for a set count
// --------------------------------------------------------------------------

module tb_clock_gen #(
    parameter realtime PERIOD       = 10ns,
    parameter int      RESET_CYCLES = 4
) (
    output logic clk,
    output logic reset
);

    timeunit 1ns;
    timeprecision 1ps;

    initial
    begin
        clk = 1'b0;
        forever
            #(PERIOD / 2) clk = ~clk;
    end

    // release just after an edge, like the rest of the stimulus
    initial
    begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 reset = 1'b0;
    end

endmodule

//--- test/tb_decode_exec.sv
// --------------------------------------------------------------------------
// decode / execute slice testbench
// pushes RV32I ALU words over Wishbone, tracks a reference register model
// and compares register and status reads against it
// --------------------------------------------------------------------------

module tb_decode_exec;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int REG_COUNT = 32;
    localparam int ACK_TIMEOUT = 100;

    logic        clk;
    logic        reset;
    logic        cyc;
    logic        stb;
    logic        we;
    logic [11:0] adr;
    logic [31:0] dat_i;
    logic [3:0]  sel;
    logic [31:0] dat_o;
    logic        ack;

    // reference state
    logic [31:0] model_regs [32];
    logic [31:0] model_illegal;
    int          error_count;
    integer      seed;

    tb_clock_gen #(.PERIOD(10ns), .RESET_CYCLES(4)) clock_i (.clk(clk), .reset(reset));

    decode_exec_top #(.REG_COUNT(REG_COUNT)) dut_i (
        .clk(clk), .reset(reset), .cyc(cyc), .stb(stb), .we(we), .adr(adr),
        .dat_i(dat_i), .sel(sel), .dat_o(dat_o), .ack(ack)
    );

    // --------------------------------------------------------------------------
    // reference model

    // decode and execute one word straight from the RV32I encoding rules
    function automatic exec_core_pkg::exec_result_t ref_exec(input logic [31:0] word,
                                                            input logic [31:0] regs [32]);
        exec_core_pkg::exec_result_t r;
        logic [6:0]  opc;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [31:0] a;
        logic [31:0] b;
        logic        alt;
        logic        ok;
        opc = word[6:0];
        f3  = word[14:12];
        f7  = word[31:25];
        alt = (f7 == 7'h20);
        a   = regs[word[19:15]];
        b   = (opc == 7'b0110011) ? regs[word[24:20]] : {{20{word[31]}}, word[31:20]};
        r   = '0;
        r.valid = 1'b1;
        r.rd    = word[11:7];
        ok      = 1'b1;
        if (opc == 7'b0110111)
            r.value = {word[31:12], 12'h000};
        else if (opc == 7'b0010011 || opc == 7'b0110011)
        begin
            // funct7 legality is stricter for the register form
            if (opc == 7'b0110011)
                ok = (f7 == 7'h00) || (alt && (f3 == 3'd0 || f3 == 3'd5));
            else if (f3 == 3'd1)
                ok = (f7 == 7'h00);
            else if (f3 == 3'd5)
                ok = (f7 == 7'h00) || alt;
            case (f3)
                3'd0: r.value = (opc == 7'b0110011 && alt) ? a - b : a + b;
                3'd1: r.value = a << b[4:0];
                3'd2: r.value = {31'b0, $signed(a) < $signed(b)};
                3'd3: r.value = {31'b0, a < b};
                3'd4: r.value = a ^ b;
                3'd5:
                begin
                    // sra and srai fill with the sign bit
                    if (alt)
                        r.value = $signed(a) >>> b[4:0];
                    else
                        r.value = a >> b[4:0];
                end
                3'd6: r.value = a | b;
                default: r.value = a & b;
            endcase
        end
        else
            ok = 1'b0;
        // register indices beyond the file
        ok = ok && (word[11:7] < REG_COUNT) && (opc == 7'b0110111 || word[19:15] < REG_COUNT)
             && (opc != 7'b0110011 || word[24:20] < REG_COUNT);
        r.illegal = !ok;
        r.write   = ok && (r.rd != 5'd0);
        return r;
    endfunction

    // encoders
    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] rand_word();
        return $random(seed);
    endfunction

    // random nonzero register index
    function automatic logic [4:0] rand_reg();
        return 5'((rand_word() % 31) + 1);
    endfunction

    // --------------------------------------------------------------------------
    // Wishbone master

    task automatic wait_ack(input string what);
        int   n;
        logic seen;
        n    = 0;
        seen = 1'b0;
        while (!seen && n < ACK_TIMEOUT)
        begin
            @(posedge clk);
            #1;
            seen = (ack === 1'b1);
            n++;
        end
        if (!seen)
        begin
            $display("no ack within %0d cycles on %s at %0t", ACK_TIMEOUT, what, $time);
            $display("Done: errors found");
            $fatal(1, "bus access timed out");
        end
    endtask

    task automatic wb_write(input logic [11:0] addr, input logic [31:0] data);
        @(posedge clk);
        #1;
        cyc   = 1'b1;
        stb   = 1'b1;
        we    = 1'b1;
        adr   = addr;
        dat_i = data;
        sel   = 4'hf;
        wait_ack($sformatf("write to address %h", addr));
        cyc = 1'b0;
        stb = 1'b0;
        we  = 1'b0;
    endtask

    task automatic wb_read(input logic [11:0] addr, output logic [31:0] data);
        @(posedge clk);
        #1;
        cyc = 1'b1;
        stb = 1'b1;
        we  = 1'b0;
        adr = addr;
        sel = 4'hf;
        wait_ack($sformatf("read of address %h", addr));
        data = dat_o;
        cyc  = 1'b0;
        stb  = 1'b0;
    endtask

    // push one word and retire it in the model too
    task automatic push(input logic [31:0] word);
        exec_core_pkg::exec_result_t r;
        r = ref_exec(word, model_regs);
        wb_write(exec_core_pkg::WB_ADDR_INSTR, word);
        if (r.write)
            model_regs[r.rd] = r.value;
        if (r.illegal)
            model_illegal = model_illegal + 32'd1;
    endtask

    // random 32-bit content via lui then addi
    task automatic load_reg(input logic [4:0] rd);
        logic [31:0] r;
        r = rand_word();
        push({r[31:12], rd, 7'b0110111});
        push(enc_i(r[11:0], rd, 3'd0, rd));
    endtask

    // --------------------------------------------------------------------------
    // compare tasks

    task automatic check_reg(input exec_core_pkg::exec_result_t got,
                             input exec_core_pkg::exec_result_t exp);
        if (got.value !== exp.value)
        begin
            error_count++;
            $display("mismatch at %0t: x%0d read %h, expected %h", $time, got.rd, got.value,
                     exp.value);
            $display("Done: errors found");
            $fatal(1, "register compare failed");
        end
    endtask

    task automatic check_count(input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp)
        begin
            error_count++;
            $display("mismatch at %0t: illegal count %0d, expected %0d", $time, got, exp);
            $display("Done: errors found");
            $fatal(1, "status compare failed");
        end
    endtask

    task automatic verify_reg(input logic [4:0] idx);
        exec_core_pkg::exec_result_t got;
        exec_core_pkg::exec_result_t exp;
        logic [31:0]                 data;
        wb_read(exec_core_pkg::WB_ADDR_REG_BASE + {5'b0, idx, 2'b00}, data);
        got       = '0;
        got.rd    = idx;
        got.value = data;
        exp       = got;
        exp.value = model_regs[idx];
        check_reg(got, exp);
    endtask

    task automatic verify_all();
        logic [31:0] data;
        for (int i = 0; i < 32; i++)
            verify_reg(5'(i));
        wb_read(exec_core_pkg::WB_ADDR_STATUS, data);
        check_count(data, model_illegal);
    endtask

    // --------------------------------------------------------------------------
    // stimulus

    initial
    begin
        int          n;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  rd;
        logic [31:0] r;
        logic [6:0]  f7;
        logic [2:0]  f3;
        cyc   = 1'b0;
        stb   = 1'b0;
        we    = 1'b0;
        adr   = '0;
        dat_i = '0;
        sel   = '0;
        seed  = 30;
        error_count   = 0;
        model_illegal = '0;
        for (int i = 0; i < 32; i++)
            model_regs[i] = '0;

        // wait out reset
        n = 0;
        while (reset !== 1'b0 && n < 100)
        begin
            @(posedge clk);
            n++;
        end
        if (reset !== 1'b0)
        begin
            $display("reset never released at %0t", $time);
            $display("Done: errors found");
            $fatal(1, "reset stuck");
        end

        // everything zero after reset
        verify_all();

        // lui and the immediate group with shifts in both funct7 forms
        for (int k = 0; k < 36; k++)
        begin
            rs1 = rand_reg();
            rd  = rand_reg();
            r   = rand_word();
            load_reg(rs1);
            if (k % 9 == 8)
                push({r[31:12], rd, 7'b0110111});
            else if (k % 9 == 1)
                push(enc_i({7'h00, r[4:0]}, rs1, 3'd1, rd));
            else if (k % 9 == 5)
                push(enc_i({r[5] ? 7'h20 : 7'h00, r[4:0]}, rs1, 3'd5, rd));
            else
                push(enc_i(r[11:0], rs1, 3'(k % 9), rd));
            verify_reg(rd);
        end

        // register-register group with sub and sra via funct7 bit 5
        for (int k = 0; k < 40; k++)
        begin
            rs1 = rand_reg();
            rs2 = rand_reg();
            rd  = rand_reg();
            f3  = 3'(k % 8);
            f7  = ((k / 8) % 2 == 1 && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h00;
            load_reg(rs1);
            load_reg(rs2);
            push(enc_r(f7, rs2, rs1, f3, rd));
            verify_reg(rd);
        end

        // back-to-back chain through the previous rd
        rd = rand_reg();
        load_reg(rd);
        for (int k = 0; k < 12; k++)
        begin
            rs1 = rd;
            rd  = rand_reg();
            r   = rand_word();
            if (k % 2 == 0)
                push(enc_i(r[11:0], rs1, 3'd0, rd));
            else
                push(enc_r(7'h00, rs1, rs1, r[14:12], rd));
        end
        push(enc_i(12'h07b, rd, 3'd0, 5'd0));
        verify_all();

        // illegal encodings leave rd alone
        load_reg(5'd7);
        load_reg(5'd9);
        load_reg(5'd10);
        push(32'h0000_0383);
        push(enc_r(7'h01, 5'd3, 5'd4, 3'd0, 5'd9));
        push(enc_i({7'h40, 5'd3}, 5'd4, 3'd5, 5'd10));
        verify_reg(5'd7);
        verify_reg(5'd9);
        verify_reg(5'd10);
        wb_read(exec_core_pkg::WB_ADDR_STATUS, r);
        check_count(r, model_illegal);

        // random mix of legal and illegal words
        for (int k = 0; k < 200; k++)
        begin
            r  = rand_word();
            f7 = (r[30:29] == 2'b00) ? 7'(rand_word()) : (r[31] ? 7'h20 : 7'h00);
            case (rand_word() % 4)
                0: push(rand_word());
                1: push({r[31:12], r[11:7], 7'b0110111});
                2: push({f7, r[24:7], 7'b0010011});
                default: push({f7, r[24:7], 7'b0110011});
            endcase
        end
        verify_all();

        if (error_count == 0)
        begin
            $display("Done: no errors");
            $finish;
        end
        else
        begin
            $display("Done: errors found");
            $fatal(1, "checks failed");
        end
    end

endmodule

//--- sources.f
src/exec_core_pkg.sv
src/instr_decoder.sv
src/int_alu.sv
src/reg_writeback.sv
src/wb_instr_port.sv
src/decode_exec_top.sv
test/tb_clock_gen.sv
test/tb_decode_exec.sv

//--- Bender.yml
package:
  name: decode_exec_slice

sources:
  - src/exec_core_pkg.sv
  - src/instr_decoder.sv
  - src/int_alu.sv
  - src/reg_writeback.sv
  - src/wb_instr_port.sv
  - src/decode_exec_top.sv
  - target: test
    files:
      - test/tb_clock_gen.sv
      - test/tb_decode_exec.sv
